// File: Bender.yml
package:
  name: cache_subsystem

sources:
  - hdl/cache_pkg.sv
  - hdl/main_memory.sv
  - hdl/mem_arbiter.sv
  - hdl/icache.sv
  - hdl/dcache.sv
  - hdl/cache_subsystem.sv
  - target: test
    files:
      - test/cache_assertions.sv
      - test/tb_cache_subsystem.sv

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 8;

	// both caches share one geometry
	localparam int LINES = 8;
	localparam int LINE_WORDS = 4;

	localparam int INDEX_W = $clog2(LINES);
	localparam int OFFSET_W = $clog2(LINE_WORDS);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// address = {tag, index, offset}
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(addr_t a);
		return a[OFFSET_W-1:0];
	endfunction

	function automatic addr_t line_addr(tag_t t, index_t i, offset_t o);
		return {t, i, o};
	endfunction

endpackage

`default_nettype wire

// File: hdl/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem
	import cache_pkg::*;
#(
	parameter int MEM_WAIT = 3
) (
	input wire clk,
	input wire reset_n,
	input wire i_if_req,
	input wire addr_t i_if_addr,
	output word_t o_if_data,
	output logic o_if_ack,
	input wire i_d_req,
	input wire i_d_we,
	input wire addr_t i_d_addr,
	input wire word_t i_d_wdata,
	output word_t o_d_rdata,
	output logic o_d_ack
);

	// icache master
	logic ic_cyc;
	logic ic_stb;
	addr_t ic_adr;
	logic ic_ack;
	word_t ic_rdat;

	// dcache master
	logic dc_cyc;
	logic dc_stb;
	logic dc_we;
	addr_t dc_adr;
	word_t dc_wdat;
	logic dc_ack;
	word_t dc_rdat;

	// shared bus to memory
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	addr_t mem_adr;
	word_t mem_wdat;
	logic mem_ack;
	word_t mem_rdat;

	icache u_icache (
		.clk(clk), .reset_n(reset_n),
		.i_if_req(i_if_req), .i_if_addr(i_if_addr),
		.o_if_data(o_if_data), .o_if_ack(o_if_ack),
		.o_wb_cyc(ic_cyc), .o_wb_stb(ic_stb), .o_wb_adr(ic_adr),
		.i_wb_ack(ic_ack), .i_wb_rdat(ic_rdat)
	);

	dcache u_dcache (
		.clk(clk), .reset_n(reset_n),
		.i_d_req(i_d_req), .i_d_we(i_d_we), .i_d_addr(i_d_addr),
		.i_d_wdata(i_d_wdata), .o_d_rdata(o_d_rdata), .o_d_ack(o_d_ack),
		.o_wb_cyc(dc_cyc), .o_wb_stb(dc_stb), .o_wb_we(dc_we),
		.o_wb_adr(dc_adr), .o_wb_wdat(dc_wdat),
		.i_wb_ack(dc_ack), .i_wb_rdat(dc_rdat)
	);

	mem_arbiter u_arbiter (
		.clk(clk), .reset_n(reset_n),
		.i_ic_cyc(ic_cyc), .i_ic_stb(ic_stb), .i_ic_adr(ic_adr),
		.o_ic_ack(ic_ack), .o_ic_rdat(ic_rdat),
		.i_dc_cyc(dc_cyc), .i_dc_stb(dc_stb), .i_dc_we(dc_we),
		.i_dc_adr(dc_adr), .i_dc_wdat(dc_wdat),
		.o_dc_ack(dc_ack), .o_dc_rdat(dc_rdat),
		.o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb), .o_mem_we(mem_we),
		.o_mem_adr(mem_adr), .o_mem_wdat(mem_wdat),
		.i_mem_ack(mem_ack), .i_mem_rdat(mem_rdat)
	);

	main_memory #(
		.MEM_WAIT(MEM_WAIT)
	) u_memory (
		.clk(clk), .reset_n(reset_n),
		.i_wb_cyc(mem_cyc), .i_wb_stb(mem_stb), .i_wb_we(mem_we),
		.i_wb_adr(mem_adr), .i_wb_wdat(mem_wdat),
		.o_wb_ack(mem_ack), .o_wb_rdat(mem_rdat)
	);

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
	import cache_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire i_d_req,
	input wire i_d_we,
	input wire addr_t i_d_addr,
	input wire word_t i_d_wdata,
	output word_t o_d_rdata,
	output logic o_d_ack,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output addr_t o_wb_adr,
	output word_t o_wb_wdat,
	input wire i_wb_ack,
	input wire word_t i_wb_rdat
);

	typedef enum logic [1:0] {
		DC_IDLE,
		DC_WRITEBACK,
		DC_REFILL,
		DC_RESPOND
	} dc_state_t;

	dc_state_t state;
	tag_t tags [LINES];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;
	word_t lines [LINES][LINE_WORDS];

	offset_t xfer_cnt;
	offset_t xfer_next;
	tag_t req_tag;
	index_t req_index;
	offset_t req_offset;
	tag_t victim_tag;
	logic hit;
	logic victim_dirty;
	logic accept;
	logic wb_step;
	logic fill_we;
	logic xfer_last;
	logic word_we;

	assign req_tag = addr_tag(i_d_addr);
	assign req_index = addr_index(i_d_addr);
	assign req_offset = addr_offset(i_d_addr);
	assign victim_tag = tags[req_index];

	assign hit = valid[req_index] && (victim_tag == req_tag);
	assign victim_dirty = valid[req_index] && dirty[req_index];
	assign accept = (state == DC_IDLE) && i_d_req && !o_d_ack;

	assign wb_step = (state == DC_WRITEBACK) && i_wb_ack;
	assign fill_we = (state == DC_REFILL) && i_wb_ack;
	assign xfer_last = (xfer_cnt == offset_t'(LINE_WORDS - 1));
	assign xfer_next = xfer_cnt + 2'd1;

	// store the word on a write hit, or once the line is in after a miss
	assign word_we = i_d_we && ((accept && hit) || (state == DC_RESPOND));

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= DC_IDLE;
			valid <= '0;
			dirty <= '0;
			xfer_cnt <= '0;
			o_d_ack <= 1'b0;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
			o_wb_we <= 1'b0;
		end else begin
			o_d_ack <= 1'b0;
			if (word_we) begin
				dirty[req_index] <= 1'b1;
			end
			case (state)
				DC_IDLE: begin
					if (accept) begin
						if (hit) begin
							o_d_ack <= 1'b1;
						end else begin
							o_wb_cyc <= 1'b1;
							o_wb_stb <= 1'b1;
							o_wb_we <= victim_dirty;
							xfer_cnt <= '0;
							state <= victim_dirty ? DC_WRITEBACK : DC_REFILL;
						end
					end
				end
				DC_WRITEBACK: begin
					if (i_wb_ack) begin
						xfer_cnt <= xfer_next;
						// cyc stays up straight into the refill
						if (xfer_last) begin
							o_wb_we <= 1'b0;
							state <= DC_REFILL;
						end
					end
				end
				DC_REFILL: begin
					if (i_wb_ack) begin
						xfer_cnt <= xfer_next;
						if (xfer_last) begin
							o_wb_cyc <= 1'b0;
							o_wb_stb <= 1'b0;
							valid[req_index] <= 1'b1;
							dirty[req_index] <= 1'b0;
							state <= DC_RESPOND;
						end
					end
				end
				DC_RESPOND: begin
					o_d_ack <= 1'b1;
					state <= DC_IDLE;
				end
				default: state <= DC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_we) begin
			lines[req_index][xfer_cnt] <= i_wb_rdat;
		end else if (word_we) begin
			lines[req_index][req_offset] <= i_d_wdata;
		end
		if (fill_we && xfer_last) begin
			tags[req_index] <= req_tag;
		end
		o_d_rdata <= lines[req_index][req_offset];
	end

	// bus address and write data for the next transfer
	always_ff @(posedge clk) begin
		if (state == DC_IDLE) begin
			if (victim_dirty) begin
				o_wb_adr <= line_addr(victim_tag, req_index, '0);
			end else begin
				o_wb_adr <= line_addr(req_tag, req_index, '0);
			end
			o_wb_wdat <= lines[req_index][0];
		end else if (wb_step) begin
			if (xfer_last) begin
				o_wb_adr <= line_addr(req_tag, req_index, '0);
			end else begin
				o_wb_adr <= line_addr(victim_tag, req_index, xfer_next);
			end
			o_wb_wdat <= lines[req_index][xfer_next];
		end else if (fill_we) begin
			o_wb_adr <= line_addr(req_tag, req_index, xfer_next);
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
	import cache_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire i_if_req,
	input wire addr_t i_if_addr,
	output word_t o_if_data,
	output logic o_if_ack,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output addr_t o_wb_adr,
	input wire i_wb_ack,
	input wire word_t i_wb_rdat
);

	typedef enum logic [1:0] {IC_IDLE, IC_REFILL, IC_RESPOND} ic_state_t;

	ic_state_t state;
	tag_t tags [LINES];
	logic [LINES-1:0] valid;
	word_t lines [LINES][LINE_WORDS];

	offset_t fill_cnt;
	offset_t fill_next;
	tag_t req_tag;
	index_t req_index;
	offset_t req_offset;
	logic hit;
	logic fill_we;
	logic fill_last;

	// requester holds the address stable until the ack
	assign req_tag = addr_tag(i_if_addr);
	assign req_index = addr_index(i_if_addr);
	assign req_offset = addr_offset(i_if_addr);

	assign hit = valid[req_index] && (tags[req_index] == req_tag);
	assign fill_we = (state == IC_REFILL) && i_wb_ack;
	assign fill_last = (fill_cnt == offset_t'(LINE_WORDS - 1));
	assign fill_next = fill_cnt + 2'd1;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IC_IDLE;
			valid <= '0;
			fill_cnt <= '0;
			o_if_ack <= 1'b0;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end else begin
			o_if_ack <= 1'b0;
			case (state)
				IC_IDLE: begin
					if (i_if_req && !o_if_ack) begin
						if (hit) begin
							o_if_ack <= 1'b1;
						end else begin
							o_wb_cyc <= 1'b1;
							o_wb_stb <= 1'b1;
							fill_cnt <= '0;
							state <= IC_REFILL;
						end
					end
				end
				IC_REFILL: begin
					if (i_wb_ack) begin
						fill_cnt <= fill_next;
						if (fill_last) begin
							o_wb_cyc <= 1'b0;
							o_wb_stb <= 1'b0;
							valid[req_index] <= 1'b1;
							state <= IC_RESPOND;
						end
					end
				end
				IC_RESPOND: begin
					o_if_ack <= 1'b1;
					state <= IC_IDLE;
				end
				default: state <= IC_IDLE;
			endcase
		end
	end

	// line storage, read word and bus address
	always_ff @(posedge clk) begin
		if (fill_we) begin
			lines[req_index][fill_cnt] <= i_wb_rdat;
		end
		if (fill_we && fill_last) begin
			tags[req_index] <= req_tag;
		end
		if (state == IC_IDLE) begin
			o_wb_adr <= line_addr(req_tag, req_index, '0);
		end else if (fill_we) begin
			o_wb_adr <= line_addr(req_tag, req_index, fill_next);
		end
		o_if_data <= lines[req_index][req_offset];
	end

endmodule

`default_nettype wire

// File: hdl/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory
	import cache_pkg::*;
#(
	parameter int MEM_WAIT = 3
) (
	input wire clk,
	input wire reset_n,
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,
	input wire addr_t i_wb_adr,
	input wire word_t i_wb_wdat,
	output logic o_wb_ack,
	output word_t o_wb_rdat
);

	localparam int DEPTH = 1 << ADDR_W;

	word_t mem [DEPTH];
	logic [2:0] wait_cnt;
	logic active;

	assign active = i_wb_cyc && i_wb_stb && !o_wb_ack;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			o_wb_ack <= 1'b0;
			wait_cnt <= '0;
			// whole array clears within a single reset cycle
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			o_wb_ack <= 1'b0;
			if (active) begin
				if (wait_cnt == 3'(MEM_WAIT)) begin
					o_wb_ack <= 1'b1;
					wait_cnt <= '0;
					o_wb_rdat <= mem[i_wb_adr];
					if (i_wb_we) begin
						mem[i_wb_adr] <= i_wb_wdat;
					end
				end else begin
					wait_cnt <= wait_cnt + 3'd1;
				end
			end else begin
				wait_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
	import cache_pkg::*;
(
	input wire clk,
	input wire reset_n,
	input wire i_ic_cyc,
	input wire i_ic_stb,
	input wire addr_t i_ic_adr,
	output logic o_ic_ack,
	output word_t o_ic_rdat,
	input wire i_dc_cyc,
	input wire i_dc_stb,
	input wire i_dc_we,
	input wire addr_t i_dc_adr,
	input wire word_t i_dc_wdat,
	output logic o_dc_ack,
	output word_t o_dc_rdat,
	output logic o_mem_cyc,
	output logic o_mem_stb,
	output logic o_mem_we,
	output addr_t o_mem_adr,
	output word_t o_mem_wdat,
	input wire i_mem_ack,
	input wire word_t i_mem_rdat
);

	typedef enum logic [1:0] {GNT_NONE, GNT_IC, GNT_DC} gnt_state_t;

	gnt_state_t state;
	logic last_dc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= GNT_NONE;
			last_dc <= 1'b0;
		end else begin
			case (state)
				GNT_NONE: begin
					// on contention the other master goes first
					if (i_dc_cyc && (!i_ic_cyc || !last_dc)) begin
						state <= GNT_DC;
						last_dc <= 1'b1;
					end else if (i_ic_cyc) begin
						state <= GNT_IC;
						last_dc <= 1'b0;
					end
				end
				GNT_IC: if (!i_ic_cyc) state <= GNT_NONE;
				GNT_DC: if (!i_dc_cyc) state <= GNT_NONE;
				default: state <= GNT_NONE;
			endcase
		end
	end

	always_comb begin
		o_mem_cyc = 1'b0;
		o_mem_stb = 1'b0;
		o_mem_we = 1'b0;
		o_mem_adr = i_ic_adr;
		if (state == GNT_IC) begin
			o_mem_cyc = i_ic_cyc;
			o_mem_stb = i_ic_stb;
		end else if (state == GNT_DC) begin
			o_mem_cyc = i_dc_cyc;
			o_mem_stb = i_dc_stb;
			o_mem_we = i_dc_we;
			o_mem_adr = i_dc_adr;
		end
	end

	// only the dcache ever writes
	assign o_mem_wdat = i_dc_wdat;

	assign o_ic_ack = (state == GNT_IC) && i_mem_ack;
	assign o_dc_ack = (state == GNT_DC) && i_mem_ack;
	assign o_ic_rdat = (state == GNT_IC) ? i_mem_rdat : '0;
	assign o_dc_rdat = (state == GNT_DC) ? i_mem_rdat : '0;

endmodule

`default_nettype wire

// File: test/cache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assertions (
	input wire clk,
	input wire reset_n,
	input wire i_if_req,
	input wire i_if_ack,
	input wire i_d_req,
	input wire i_d_ack,
	input wire i_ic_ack,
	input wire i_dc_ack,
	input wire i_mem_cyc,
	input wire i_mem_stb,
	input wire i_mem_ack
);

	logic seen_req;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			seen_req <= 1'b0;
		end else if (i_if_req || i_d_req) begin
			seen_req <= 1'b1;
		end
	end

	// the requester may drop its request during the ack cycle
	a_if_ack: assert property (@(posedge clk) disable iff (!reset_n)
		i_if_ack |-> $past(i_if_req)) else $error("fetch ack without a request");

	a_d_ack: assert property (@(posedge clk) disable iff (!reset_n)
		i_d_ack |-> $past(i_d_req)) else $error("data ack without a request");

	a_mem_ack: assert property (@(posedge clk) disable iff (!reset_n)
		i_mem_ack |-> (i_mem_cyc && i_mem_stb)) else $error("memory ack outside a cycle");

	// every memory ack lands on exactly one master
	a_one_master: assert property (@(posedge clk) disable iff (!reset_n)
		i_mem_ack |-> (i_ic_ack != i_dc_ack))
		else $error("memory ack not routed to exactly one master");

	a_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		!seen_req |-> !(i_if_ack || i_d_ack || i_mem_ack)) else $error("ack before any request");

endmodule

bind cache_subsystem cache_assertions u_assertions (
	.clk(clk), .reset_n(reset_n),
	.i_if_req(i_if_req), .i_if_ack(o_if_ack),
	.i_d_req(i_d_req), .i_d_ack(o_d_ack),
	.i_ic_ack(ic_ack), .i_dc_ack(dc_ack),
	.i_mem_cyc(mem_cyc), .i_mem_stb(mem_stb), .i_mem_ack(mem_ack)
);

`default_nettype wire

// File: test/tb_cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;

	localparam int TIMEOUT = 200;

	logic clk;
	logic reset_n;
	logic i_if_req;
	logic [7:0] i_if_addr;
	logic [15:0] o_if_data;
	logic o_if_ack;
	logic i_d_req;
	logic i_d_we;
	logic [7:0] i_d_addr;
	logic [15:0] i_d_wdata;
	logic [15:0] o_d_rdata;
	logic o_d_ack;

	// reference model of memory and both caches
	logic [15:0] model_mem [256];
	logic [2:0] ic_tag [8];
	logic [7:0] ic_valid;
	logic [15:0] ic_data [8][4];
	logic [2:0] dc_tag [8];
	logic [7:0] dc_valid;
	logic [7:0] dc_dirty;
	logic [15:0] dc_data [8][4];

	integer seed;
	logic [31:0] r;
	logic [2:0] fixed_tag;
	logic [7:0] fetch_addr [80];
	logic [7:0] data_addr [80];
	logic data_we [80];
	logic [15:0] data_wdata [80];

	cache_subsystem #(
		.MEM_WAIT(3)
	) uut (
		.clk(clk), .reset_n(reset_n),
		.i_if_req(i_if_req), .i_if_addr(i_if_addr),
		.o_if_data(o_if_data), .o_if_ack(o_if_ack),
		.i_d_req(i_d_req), .i_d_we(i_d_we), .i_d_addr(i_d_addr),
		.i_d_wdata(i_d_wdata), .o_d_rdata(o_d_rdata), .o_d_ack(o_d_ack)
	);

	always #50 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		if (got !== expected) begin
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
		end
	endtask

	// icache policy: read-only, refill whole line from memory on a miss
	function automatic logic [15:0] model_fetch(input logic [7:0] addr);
		logic [2:0] tag;
		logic [2:0] idx;
		logic [7:0] base;
		tag = addr[7:5];
		idx = addr[4:2];
		base = {tag, idx, 2'b00};
		if (!(ic_valid[idx] && ic_tag[idx] == tag)) begin
			for (int w = 0; w < 4; w++) begin
				ic_data[idx][w] = model_mem[base + w];
			end
			ic_tag[idx] = tag;
			ic_valid[idx] = 1'b1;
		end
		return ic_data[idx][addr[1:0]];
	endfunction

	// dcache policy: write-allocate, write-back of a dirty victim before refill
	function automatic logic [15:0] model_data(input logic we, input logic [7:0] addr,
			input logic [15:0] wdata);
		logic [2:0] tag;
		logic [2:0] idx;
		logic [7:0] base;
		logic [7:0] victim;
		tag = addr[7:5];
		idx = addr[4:2];
		base = {tag, idx, 2'b00};
		victim = {dc_tag[idx], idx, 2'b00};
		if (!(dc_valid[idx] && dc_tag[idx] == tag)) begin
			if (dc_valid[idx] && dc_dirty[idx]) begin
				for (int w = 0; w < 4; w++) begin
					model_mem[victim + w] = dc_data[idx][w];
				end
			end
			for (int w = 0; w < 4; w++) begin
				dc_data[idx][w] = model_mem[base + w];
			end
			dc_tag[idx] = tag;
			dc_valid[idx] = 1'b1;
			dc_dirty[idx] = 1'b0;
		end
		if (we) begin
			dc_data[idx][addr[1:0]] = wdata;
			dc_dirty[idx] = 1'b1;
		end
		return dc_data[idx][addr[1:0]];
	endfunction

	task automatic data_access(input logic we, input logic [7:0] addr, input logic [15:0] wdata);
		logic [15:0] expected;
		int cycles;
		expected = model_data(we, addr, wdata);
		i_d_req = 1'b1;
		i_d_we = we;
		i_d_addr = addr;
		i_d_wdata = wdata;
		@(negedge clk);
		cycles = 1;
		while (!o_d_ack && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!o_d_ack) begin
			report_failure($sformatf("timeout: data port never acknowledged address %h", addr));
		end
		i_d_req = 1'b0;
		if (!we) begin
			check_value("o_d_rdata", o_d_rdata, expected);
		end
	endtask

	task automatic fetch(input logic [7:0] addr);
		logic [15:0] expected;
		int cycles;
		expected = model_fetch(addr);
		i_if_req = 1'b1;
		i_if_addr = addr;
		@(negedge clk);
		cycles = 1;
		while (!o_if_ack && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!o_if_ack) begin
			report_failure($sformatf("timeout: fetch port never acknowledged address %h", addr));
		end
		i_if_req = 1'b0;
		check_value("o_if_data", o_if_data, expected);
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		i_if_req = 1'b0;
		i_if_addr = '0;
		i_d_req = 1'b0;
		i_d_we = 1'b0;
		i_d_addr = '0;
		i_d_wdata = '0;
		seed = 32'h21f6_a278;
		for (int a = 0; a < 256; a++) begin
			model_mem[a] = '0;
		end
		ic_valid = '0;
		dc_valid = '0;
		dc_dirty = '0;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;

		// first touch misses, second is a hit; memory is all zero
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			data_access(1'b0, r[7:0], '0);
			data_access(1'b0, r[7:0], '0);
		end

		// one tag only, so no two lines compete for an index
		r = $random(seed);
		fixed_tag = r[2:0];
		for (int i = 0; i < 60; i++) begin
			r = $random(seed);
			data_access(r[8], {fixed_tag, r[4:0]}, r[31:16]);
		end

		// whole range forces dirty evictions
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			data_access(r[8], r[7:0], r[31:16]);
		end

		// strictly sequential fetches and data operations
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			if (r[9]) begin
				fetch(r[7:0]);
			end else begin
				data_access(r[8], r[7:0], r[31:16]);
			end
		end

		// move every dcache line into the upper half before the ports run together
		for (int i = 0; i < 8; i++) begin
			data_access(1'b0, 8'h80 | (i << 2), '0);
		end
		for (int i = 0; i < 80; i++) begin
			r = $random(seed);
			fetch_addr[i] = {1'b0, r[6:0]};
			data_addr[i] = {1'b1, r[14:8]};
			data_we[i] = r[15];
			data_wdata[i] = r[31:16];
		end
		fork
			begin
				for (int i = 0; i < 80; i++) begin
					fetch(fetch_addr[i]);
				end
			end
			begin
				for (int j = 0; j < 80; j++) begin
					data_access(data_we[j], data_addr[j], data_wdata[j]);
				end
			end
		join

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/cache_pkg.sv
hdl/main_memory.sv
hdl/mem_arbiter.sv
hdl/icache.sv
hdl/dcache.sv
hdl/cache_subsystem.sv
test/cache_assertions.sv
test/tb_cache_subsystem.sv
